/* bank_read_if.sv */
// Buffer to drain read port
`default_nettype none

interface bank_read_if #(
    parameter int SAMPLE_WIDTH = sample_pkg::SAMPLE_WIDTH,
    parameter int FRAME_LOG2   = frame_pkg::FRAME_LOG2
);

    logic [FRAME_LOG2-1:0]   rd_addr;         // Natural order address
    logic [SAMPLE_WIDTH-1:0] rd_data;         // Valid one cycle after rd_addr

    // A full bank is waiting
    logic                    bank_full_req;

    // Drain finished, four-phase
    logic                    drain_done_req;
    logic                    drain_done_ack;

    modport buffer (
        input  rd_addr,
        output rd_data,
        output bank_full_req,
        input  drain_done_req,
        output drain_done_ack
    );

    modport drain (
        output rd_addr,
        input  rd_data,
        input  bank_full_req,
        output drain_done_req,
        input  drain_done_ack
    );

endinterface

`default_nettype wire

/* bank_write_if.sv */
// Capture to buffer write port
`default_nettype none

interface bank_write_if #(
    parameter int SAMPLE_WIDTH = sample_pkg::SAMPLE_WIDTH,
    parameter int FRAME_LOG2   = frame_pkg::FRAME_LOG2
);

    logic                    wr_en;     // One sample write this cycle
    logic [FRAME_LOG2-1:0]   wr_addr;   // Already bit-reversed
    logic [SAMPLE_WIDTH-1:0] wr_data;

    // Frame hand-over, four-phase
    logic                    fill_req;
    logic                    fill_ack;

    modport capture (
        output wr_en,
        output wr_addr,
        output wr_data,
        output fill_req,
        input  fill_ack
    );

    modport buffer (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  fill_req,
        output fill_ack
    );

endinterface

`default_nettype wire

/* build.f */
sample_pkg.sv
frame_pkg.sv
bank_write_if.sv
bank_read_if.sv
result_capture.sv
reorder_bank.sv
frame_drain.sv
fft_reorder_top.sv
fft_reorder_props.sv
tb_fft_reorder.sv

/* fft_reorder_props.sv */
// Output handshake assertions
`default_nettype none

module fft_reorder_props (
    input logic                clock,
    input logic                fft_reset,
    input logic                out_req,
    input logic                out_ack,
    input sample_pkg::sample_t out_data
);

    timeunit 1ns;
    timeprecision 100ps;

    int hold_fails  = 0;
    int ack_fails   = 0;
    int reset_fails = 0;
    int failures;                               // Read by the testbench at the end

    assign failures = hold_fails + ack_fails + reset_fails;

    // Request and data held until the ack arrives
    req_held: assert property (@(posedge clock) disable iff (fft_reset)
        out_req && !out_ack |=> out_req && $stable(out_data))
    else begin
        hold_fails++;
        $error("out_req dropped or out_data changed before out_ack");
    end

    ack_needs_req: assert property (@(posedge clock) disable iff (fft_reset)
        $rose(out_ack) |-> out_req)
    else begin
        ack_fails++;
        $error("out_ack rose while out_req was low");
    end

    // No output request while the unit is held in reset
    req_low_in_reset: assert property (@(posedge clock)
        fft_reset |-> !out_req)
    else begin
        reset_fails++;
        $error("out_req high during fft_reset");
    end

endmodule

bind fft_reorder_top fft_reorder_props props (
    .clock     (clock),
    .fft_reset (fft_reset),
    .out_req   (out_req),
    .out_ack   (out_ack),
    .out_data  (out_data)
);

`default_nettype wire

/* fft_reorder_top.sv */
// FFT output reorder unit
`default_nettype none

module fft_reorder_top #(
    parameter int SAMPLE_WIDTH = sample_pkg::SAMPLE_WIDTH,
    parameter int FRAME_LOG2   = frame_pkg::FRAME_LOG2
) (
    input  logic                clock,
    input  logic                fft_reset,
    // Bit-reversed FFT stream in
    input  logic                sample_valid,
    input  sample_pkg::sample_t sample_real,
    output logic                sample_ready,
    // Natural order samples out
    output logic                out_req,
    input  logic                out_ack,
    output sample_pkg::sample_t out_data,
    output frame_pkg::index_t   out_index
);

    bank_write_if #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .FRAME_LOG2   (FRAME_LOG2)
    ) wr_bus ();

    bank_read_if #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .FRAME_LOG2   (FRAME_LOG2)
    ) rd_bus ();

    result_capture #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .FRAME_LOG2   (FRAME_LOG2)
    ) u_capture (
        .clock        (clock),
        .fft_reset    (fft_reset),
        .sample_valid (sample_valid),
        .sample_real  (sample_real),
        .sample_ready (sample_ready),
        .wr           (wr_bus.capture)
    );

    reorder_bank #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .FRAME_LOG2   (FRAME_LOG2)
    ) u_bank (
        .clock        (clock),
        .fft_reset    (fft_reset),
        .wr           (wr_bus.buffer),
        .rd           (rd_bus.buffer)
    );

    frame_drain #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .FRAME_LOG2   (FRAME_LOG2)
    ) u_drain (
        .clock        (clock),
        .fft_reset    (fft_reset),
        .rd           (rd_bus.drain),
        .out_ack      (out_ack),
        .out_req      (out_req),
        .out_data     (out_data),
        .out_index    (out_index)
    );

endmodule

`default_nettype wire

/* frame_drain.sv */
// Natural order frame drain
`default_nettype none

module frame_drain #(
    parameter int SAMPLE_WIDTH = sample_pkg::SAMPLE_WIDTH,
    parameter int FRAME_LOG2   = frame_pkg::FRAME_LOG2
) (
    input  logic                clock,
    input  logic                fft_reset,
    bank_read_if.drain          rd,
    input  logic                out_ack,
    output logic                out_req,
    output sample_pkg::sample_t out_data,
    output frame_pkg::index_t   out_index
);

    import sample_pkg::*;
    import frame_pkg::*;

    // Drain FSM encoding
    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_READ      = 3'd1;  // rd_addr presented
    localparam logic [2:0] ST_LOAD      = 3'd2;  // rd_data valid
    localparam logic [2:0] ST_WAIT_ACK  = 3'd3;
    localparam logic [2:0] ST_RELEASE   = 3'd4;  // Waiting for out_ack low
    localparam logic [2:0] ST_DONE      = 3'd5;
    localparam logic [2:0] ST_DONE_DROP = 3'd6;

    logic [2:0]              state;
    logic [FRAME_LOG2-1:0]   addr;
    logic [SAMPLE_WIDTH-1:0] hold_data;   // Sample on the output bus

    assign rd.rd_addr = addr;
    assign out_data   = sample_t'(hold_data);
    assign out_index  = index_t'(addr);     // Steady while out_req is high

    always_ff @(posedge clock) begin
        if (state == ST_LOAD) begin
            hold_data <= rd.rd_data;
        end
    end

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            state             <= ST_IDLE;
            addr              <= '0;
            out_req           <= 1'b0;
            rd.drain_done_req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rd.bank_full_req) begin
                        addr  <= '0;          // Start of a frame
                        state <= ST_READ;
                    end
                end
                ST_READ: state <= ST_LOAD;
                ST_LOAD: begin
                    out_req <= 1'b1;
                    state   <= ST_WAIT_ACK;
                end
                ST_WAIT_ACK: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    if (!out_ack && (&addr)) begin
                        rd.drain_done_req <= 1'b1;   // Whole bank sent
                        state             <= ST_DONE;
                    end else if (!out_ack) begin
                        addr  <= addr + 1'b1;
                        state <= ST_READ;
                    end
                end
                ST_DONE: begin
                    if (rd.drain_done_ack) begin
                        rd.drain_done_req <= 1'b0;
                        state             <= ST_DONE_DROP;
                    end
                end
                ST_DONE_DROP: if (!rd.drain_done_ack) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* frame_pkg.sv */
// Frame geometry and bit reversal
`default_nettype none

package frame_pkg;

    // 64-point frames by default
    localparam int FRAME_LOG2 = 6;

    // Position of a sample inside one frame
    typedef logic [FRAME_LOG2-1:0] index_t;

    // One of the two buffer banks
    typedef logic bank_t;

    // Mirror the index bits, MSB becomes LSB
    function automatic index_t bit_reverse(input index_t idx);
        index_t rev;
        for (int i = 0; i < FRAME_LOG2; i++) begin
            rev[i] = idx[FRAME_LOG2-1-i];
        end
        return rev;
    endfunction

endpackage

`default_nettype wire

/* reorder_bank.sv */
// Two-bank frame buffer
`default_nettype none

module reorder_bank #(
    parameter int SAMPLE_WIDTH = sample_pkg::SAMPLE_WIDTH,
    parameter int FRAME_LOG2   = frame_pkg::FRAME_LOG2
) (
    input  logic          clock,
    input  logic          fft_reset,
    bank_write_if.buffer  wr,
    bank_read_if.buffer   rd
);

    import frame_pkg::*;

    // Sample storage, one frame per bank
    logic [SAMPLE_WIDTH-1:0] mem [2][1 << FRAME_LOG2];

    logic [1:0]              full;        // Bank holds a complete frame
    bank_t                   fill_ptr;    // Bank owned by the capture stage
    bank_t                   drain_ptr;   // Oldest full bank
    logic                    fill_ack_q;
    logic                    full_req_q;
    logic                    done_ack_q;
    logic [SAMPLE_WIDTH-1:0] rd_data_q;

    assign wr.fill_ack       = fill_ack_q;
    assign rd.bank_full_req  = full_req_q;
    assign rd.drain_done_ack = done_ack_q;
    assign rd.rd_data        = rd_data_q;

    // Write into the fill bank, synchronous read from the drain bank
    always_ff @(posedge clock) begin
        if (wr.wr_en) begin
            mem[fill_ptr][wr.wr_addr] <= wr.wr_data;
        end
        rd_data_q <= mem[drain_ptr][rd.rd_addr];
    end

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            full       <= 2'b00;
            fill_ptr   <= 1'b0;
            drain_ptr  <= 1'b0;
            fill_ack_q <= 1'b0;
            full_req_q <= 1'b0;
            done_ack_q <= 1'b0;
        end else begin
            // Fill side, hand over only when the other bank is free
            if (wr.fill_req && !fill_ack_q && !full[~fill_ptr]) begin
                fill_ack_q     <= 1'b1;
                full[fill_ptr] <= 1'b1;
                fill_ptr       <= ~fill_ptr;
            end else if (!wr.fill_req && fill_ack_q) begin
                fill_ack_q <= 1'b0;
            end

            // Drain side; the two sides never touch the same bank flag
            if (rd.drain_done_req && !done_ack_q) begin
                full[drain_ptr] <= 1'b0;
                drain_ptr       <= ~drain_ptr;
                done_ack_q      <= 1'b1;
                full_req_q      <= 1'b0;
            end else if (!rd.drain_done_req && done_ack_q) begin
                done_ack_q <= 1'b0;
            end else if (!done_ack_q && !full_req_q && full[drain_ptr]) begin
                full_req_q <= 1'b1;          // Next frame ready for the drain
            end
        end
    end

endmodule

`default_nettype wire

/* result_capture.sv */
// FFT result capture
`default_nettype none

module result_capture #(
    parameter int SAMPLE_WIDTH = sample_pkg::SAMPLE_WIDTH,
    parameter int FRAME_LOG2   = frame_pkg::FRAME_LOG2
) (
    input  logic                clock,
    input  logic                fft_reset,
    input  logic                sample_valid,
    input  sample_pkg::sample_t sample_real,
    output logic                sample_ready,
    bank_write_if.capture       wr
);

    import frame_pkg::*;

    // Capture FSM encoding
    localparam logic [1:0] ST_FILL    = 2'd0;  // Accepting samples
    localparam logic [1:0] ST_REQ     = 2'd1;  // Frame complete, fill_req high
    localparam logic [1:0] ST_RELEASE = 2'd2;  // Waiting for fill_ack to fall

    logic [1:0]            state;
    logic [FRAME_LOG2-1:0] count;              // Arrival position in the frame
    logic                  accept;

    assign sample_ready = (state == ST_FILL);
    assign accept       = sample_valid & sample_ready;

    // Each accepted sample lands at its bit-reversed slot in the same cycle
    assign wr.wr_en    = accept;
    assign wr.wr_addr  = bit_reverse(index_t'(count));
    assign wr.wr_data  = SAMPLE_WIDTH'(sample_real);
    assign wr.fill_req = (state == ST_REQ);

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            state <= ST_FILL;
            count <= '0;                        // Partial frame is dropped
        end else begin
            case (state)
                ST_FILL: begin
                    if (accept) begin
                        count <= count + 1'b1;  // Wraps to 0 after the last one
                        if (&count) begin
                            state <= ST_REQ;
                        end
                    end
                end
                ST_REQ: begin
                    // Buffer has switched banks
                    if (wr.fill_ack) begin
                        state <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    if (!wr.fill_ack) begin
                        state <= ST_FILL;
                    end
                end
                default: begin
                    state <= ST_FILL;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the reorder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_fft_reorder -o tb_fft_reorder
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_fft_reorder +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

/* sample_pkg.sv */
// Sample word format
`default_nettype none

package sample_pkg;

    // Width of one real FFT output word
    localparam int SAMPLE_WIDTH = 16;

    // Signed real sample as delivered by the FFT core
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

endpackage

`default_nettype wire

/* tb_fft_reorder.sv */
// FFT reorder testbench
`default_nettype none

module tb_fft_reorder;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SAMPLE_WIDTH  = 16;
    localparam int FRAME_LOG2    = 6;
    localparam int FRAME_LEN     = 1 << FRAME_LOG2;
    localparam int HALF_PERIOD   = 4;
    localparam int RESET_CYCLES  = 5;
    localparam int MAX_ACK_DELAY = 6;
    localparam int PARTIAL_LEN   = 20;             // Samples of the frame cut by reset
    localparam int LONG_STALL    = 16;             // Longer than one bank hand-over
    localparam int IDLE_CYCLES   = 200;
    localparam int NUM_FRAMES    = 8;              // Seven full frames and the cut one
    localparam int WATCHDOG_NS   = NUM_FRAMES * FRAME_LEN * 12 * 2 * HALF_PERIOD;
    localparam int SEED          = 32'hddb9aad4;

    logic                    clock;
    logic                    fft_reset;
    logic                    sample_valid;
    logic [SAMPLE_WIDTH-1:0] sample_real;
    logic                    sample_ready;
    logic                    out_req;
    logic                    out_ack;
    logic [SAMPLE_WIDTH-1:0] out_data;
    logic [FRAME_LOG2-1:0]   out_index;

    int                      seed;
    int                      ack_delay;
    int                      data_errors  = 0;     // Raised by the output checker
    int                      final_errors = 0;     // Raised by the end-of-phase checks
    int                      frames_done;          // Complete frames out since reset
    int                      outs_since_reset;
    int                      stall_run;
    int                      max_stall    = 0;
    logic                    req_seen;
    logic [FRAME_LOG2-1:0]   next_index;
    logic [SAMPLE_WIDTH-1:0] part_q[$];            // Accepted samples of the open frame
    logic [SAMPLE_WIDTH-1:0] exp_q[$];             // Complete frames in arrival order

    fft_reorder_top #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .FRAME_LOG2   (FRAME_LOG2)
    ) dut (
        .clock        (clock),
        .fft_reset    (fft_reset),
        .sample_valid (sample_valid),
        .sample_real  (sample_real),
        .sample_ready (sample_ready),
        .out_req      (out_req),
        .out_ack      (out_ack),
        .out_data     (out_data),
        .out_index    (out_index)
    );

    always #(HALF_PERIOD) clock = ~clock;

    // Arrival position of the sample that belongs at natural index idx
    function automatic int mirror_index(input int idx);
        int rev;
        rev = 0;
        for (int b = 0; b < FRAME_LOG2; b++) begin
            if (idx & (1 << b)) begin
                rev = rev | (1 << (FRAME_LOG2 - 1 - b));
            end
        end
        return rev;
    endfunction

    // Offer samples back to back and hold each until accepted
    task automatic send_samples(input int count);
        int sent;
        sent = 0;
        sample_valid <= 1'b1;
        sample_real  <= SAMPLE_WIDTH'($random(seed));
        while (sent < count) begin
            @(posedge clock);
            if (sample_ready) begin
                sent++;
                if (sent < count) begin
                    sample_real <= SAMPLE_WIDTH'($random(seed));
                end else begin
                    sample_valid <= 1'b0;
                end
            end
        end
    endtask

    task automatic pulse_reset();
        fft_reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        fft_reset <= 1'b0;
    endtask

    // Compare one output sample with the oldest complete frame
    task automatic check_output();
        logic [SAMPLE_WIDTH-1:0] expected;
        if (exp_q.size() < FRAME_LEN) begin
            data_errors++;
            $display("Error at %0t: output sample seen with no complete frame pending", $time);
        end else begin
            assert (out_index == next_index) else begin
                data_errors++;
                $display("MISMATCH at %0t: out_index %0d, expected %0d",
                         $time, out_index, next_index);
            end
            expected = exp_q[mirror_index(int'(out_index))];
            assert (out_data == expected) else begin
                data_errors++;
                $display("MISMATCH at %0t: out_data %h at index %0d, expected %h",
                         $time, out_data, out_index, expected);
            end
            outs_since_reset++;
            if (int'(out_index) == FRAME_LEN - 1) begin
                for (int i = 0; i < FRAME_LEN; i++) begin
                    void'(exp_q.pop_front());
                end
                frames_done++;
            end
            next_index = FRAME_LOG2'(int'(out_index) + 1);
        end
    endtask

    // Frames become expected once all 64 samples are in
    always @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            part_q.delete();
            exp_q.delete();                        // Nothing stored survives a reset
            stall_run = 0;
        end else begin
            if (sample_valid && sample_ready) begin
                part_q.push_back(sample_real);
                if (part_q.size() == FRAME_LEN) begin
                    foreach (part_q[i]) exp_q.push_back(part_q[i]);
                    part_q.delete();
                end
            end
            stall_run = (sample_valid && !sample_ready) ? stall_run + 1 : 0;
            if (stall_run > max_stall) max_stall = stall_run;
        end
    end

    // Output checker on each rising out_req
    always @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            req_seen         = 1'b0;
            next_index       = '0;
            frames_done      = 0;
            outs_since_reset = 0;
        end else begin
            if (out_req && !req_seen) check_output();
            req_seen = out_req;
        end
    end

    // Output side responder with random ack delay
    initial begin
        out_ack = 1'b0;
        forever begin
            @(posedge clock);
            if (out_req && !out_ack && !fft_reset) begin
                ack_delay = $unsigned($random(seed)) % (MAX_ACK_DELAY + 1);
                repeat (ack_delay) @(posedge clock);
                if (out_req && !fft_reset) begin   // Request may be gone after a reset
                    out_ack <= 1'b1;
                    @(posedge clock);
                    while (out_req) begin
                        @(posedge clock);
                    end
                    out_ack <= 1'b0;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: frames did not drain within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

    initial begin
        clock        = 1'b0;
        fft_reset    = 1'b1;
        sample_valid = 1'b0;
        sample_real  = '0;
        seed         = SEED;
        repeat (RESET_CYCLES) @(posedge clock);
        fft_reset <= 1'b0;

        // Four back-to-back frames so that both banks fill
        @(posedge clock);
        send_samples(4 * FRAME_LEN);
        wait (frames_done == 4);
        repeat (IDLE_CYCLES) @(posedge clock);
        assert (outs_since_reset == 4 * FRAME_LEN) else begin
            final_errors++;
            $display("Lost or duplicated samples: %0d outputs for 4 frames", outs_since_reset);
        end
        assert (max_stall > LONG_STALL) else begin
            final_errors++;
            $display("sample_ready was never held low while both banks were full");
        end

        // One full frame and a reset in the middle of the next
        send_samples(FRAME_LEN + PARTIAL_LEN);
        while (!(out_req && !out_ack)) begin
            @(posedge clock);                      // Reset lands while a sample waits for its ack
        end
        pulse_reset();

        @(posedge clock);
        send_samples(2 * FRAME_LEN);
        wait (frames_done == 2);
        repeat (IDLE_CYCLES) @(posedge clock);
        assert (outs_since_reset == 2 * FRAME_LEN && exp_q.size() == 0) else begin
            final_errors++;
            $display("After reset %0d samples came out, %0d expected samples left over",
                     outs_since_reset, exp_q.size());
        end

        $display("Summary: %0d output errors, %0d end-of-test errors, %0d assertion failures",
                 data_errors, final_errors, dut.props.failures);
        if (data_errors == 0 && final_errors == 0 && dut.props.failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
